/* sources.f */
ifu_pkg.sv
bpu_top.sv
ifu_pc_gen.sv
ifu_fetch_axi.sv
ifu_cfg_regs.sv
ifu_top.sv
ifu_assert.sv
tb_ifu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ifu
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sources.f

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_ifu.sv */
module tb_ifu;
  import ifu_pkg::*;

  localparam logic [XLEN-1:0] BASE = 64'h100;
  localparam logic [XLEN-1:0] RDR_PC = 64'h118;

  logic clk_i, arst_n_i;
  logic [XLEN-1:0] mem_araddr_o;
  logic mem_arvalid_o, mem_arready_i, mem_rvalid_i, mem_rready_o;
  logic [ILEN-1:0] mem_rdata_i;
  logic [CFG_AW-1:0] cfg_awaddr_i, cfg_araddr_i;
  logic cfg_awvalid_i, cfg_awready_o, cfg_wvalid_i, cfg_wready_o, cfg_bvalid_o, cfg_bready_i;
  logic [CFG_DW-1:0] cfg_wdata_i, cfg_rdata_o;
  logic [CFG_DW/8-1:0] cfg_wstrb_i;
  logic [1:0] cfg_bresp_o, cfg_rresp_o;
  logic cfg_arvalid_i, cfg_arready_o, cfg_rvalid_o, cfg_rready_i;
  logic redirect_valid_i;
  logic [XLEN-1:0] redirect_pc_i, inst_pc_o;
  logic inst_valid_o, inst_ready_i, inst_pred_taken_o;
  logic [ILEN-1:0] inst_o;

  logic [ILEN-1:0] prog [12];
  logic [XLEN-1:0] model_pc, mem_addr, nxt_pc;
  logic [ILEN-1:0] exp_w;
  logic [CFG_DW-1:0] rd_val;
  logic model_en, exp_t, stall_en;
  int seed = 32'hf061_818e;
  int errors, checks, ntests, acc_cnt, jump_model, mst, mcnt, rnd;

  ifu_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [ILEN-1:0] enc_i(logic [6:0] opc, logic [4:0] rd, logic [4:0] rs1,
                                            logic [11:0] imm);
    rv_inst_u u;
    u.word = '0;
    u.i.imm = imm;
    u.i.rs1 = rs1;
    u.i.rd = rd;
    u.i.opcode = opc;
    return u.word;
  endfunction

  function automatic logic [ILEN-1:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [12:0] off);
    rv_inst_u u;
    u.word = '0;
    u.b.imm12 = off[12];
    u.b.imm10_5 = off[10:5];
    u.b.rs1 = rs1;
    u.b.funct3 = f3;
    u.b.imm4_1 = off[4:1];
    u.b.imm11 = off[11];
    u.b.opcode = OPC_BRANCH;
    return u.word;
  endfunction

  function automatic logic [ILEN-1:0] enc_j(logic [4:0] rd, logic [20:0] off);
    rv_inst_u u;
    u.word = '0;
    u.j.imm20 = off[20];
    u.j.imm10_1 = off[10:1];
    u.j.imm11 = off[11];
    u.j.imm19_12 = off[19:12];
    u.j.rd = rd;
    u.j.opcode = OPC_JAL;
    return u.word;
  endfunction

  // outside the program the memory returns an op-imm word folded from the whole address
  function automatic logic [ILEN-1:0] mem_word(logic [XLEN-1:0] a);
    logic [31:0] f;
    logic [3:0]  idx;
    idx = 4'((a - BASE) >> 2);
    if (a >= BASE && a < BASE + 48 && a[1:0] == 2'b00) return prog[idx];
    f = a[63:32] ^ a[31:0];
    return {f[31:7] ^ f[24:0], 7'h13};
  endfunction

  // static prediction from the raw instruction bits
  function automatic logic [XLEN-1:0] predict_next(logic [XLEN-1:0] pc, logic [31:0] w,
                                                   logic en, output logic taken);
    logic [XLEN-1:0] tgt;
    taken = 1'b0;
    tgt = pc;
    if (w[6:0] == OPC_BRANCH) begin
      tgt = pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      taken = w[31];
    end else if (w[6:0] == OPC_JAL) begin
      tgt = pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      taken = 1'b1;
    end else if (w[6:0] == OPC_JALR) begin
      tgt = {{52{w[31]}}, w[31:20]};
      taken = (w[19:15] == 5'd0);
    end
    taken = taken & en;
    return taken ? tgt : pc + 64'd4;
  endfunction

  task automatic check_val(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic timeout_fail(string what);
    $display("timeout while waiting for %s at time %0t", what, $time);
    $display("sim failed");
    $finish;
  endtask

  task automatic next_cycle(inout int t, input int lim, input string what);
    @(posedge clk_i);
    #1;
    t++;
    if (t > lim) timeout_fail(what);
  endtask

  task automatic cfg_write(logic [CFG_AW-1:0] addr, logic [CFG_DW-1:0] data);
    int t;
    @(posedge clk_i);
    #1;
    cfg_awaddr_i = addr;
    cfg_wdata_i = data;
    cfg_wstrb_i = '1;
    cfg_awvalid_i = 1'b1;
    cfg_wvalid_i = 1'b1;
    t = 0;
    while (!(cfg_awready_o && cfg_wready_o)) next_cycle(t, 50, "cfg write accept");
    @(posedge clk_i);
    #1;
    cfg_awvalid_i = 1'b0;
    cfg_wvalid_i = 1'b0;
    cfg_bready_i = 1'b1;
    t = 0;
    while (!cfg_bvalid_o) next_cycle(t, 50, "cfg write response");
    // OKAY is the only response
    check_val("cfg_bresp_o", {62'd0, cfg_bresp_o}, 64'd0);
    @(posedge clk_i);
    #1;
    cfg_bready_i = 1'b0;
  endtask

  task automatic cfg_read(logic [CFG_AW-1:0] addr, output logic [CFG_DW-1:0] data);
    int t;
    @(posedge clk_i);
    #1;
    cfg_araddr_i = addr;
    cfg_arvalid_i = 1'b1;
    t = 0;
    while (!cfg_arready_o) next_cycle(t, 50, "cfg read accept");
    @(posedge clk_i);
    #1;
    cfg_arvalid_i = 1'b0;
    cfg_rready_i = 1'b1;
    t = 0;
    while (!cfg_rvalid_o) next_cycle(t, 50, "cfg read data");
    data = cfg_rdata_o;
    check_val("cfg_rresp_o", {62'd0, cfg_rresp_o}, 64'd0);
    @(posedge clk_i);
    #1;
    cfg_rready_i = 1'b0;
  endtask

  task automatic start_run(logic en);
    model_pc = BASE;
    model_en = en;
    cfg_write(CFG_CTRL, {30'd0, en, 1'b1});
  endtask

  // clear run and let the fetch in flight drain
  task automatic stop_run();
    int t, quiet;
    cfg_write(CFG_CTRL, {30'd0, model_en, 1'b0});
    t = 0;
    quiet = 0;
    while (quiet < 8) begin
      next_cycle(t, 200, "fetch drain");
      quiet = (mem_arvalid_o || mem_rready_o || inst_valid_o) ? 0 : quiet + 1;
    end
  endtask

  task automatic wait_accepts(int n);
    int t, target;
    target = acc_cnt + n;
    t = 0;
    while (acc_cnt < target) next_cycle(t, 400, "accepted instructions");
  endtask

  task automatic report(string name);
    ntests++;
    $display("test %s finished, errors so far %0d", name, errors);
  endtask

  // memory read slave with 0 to 3 cycles of extra delay on AR and R
  always @(posedge clk_i) begin
    #1;
    // downstream ready toggles at random only in the back-pressure test
    rnd = $random(seed);
    inst_ready_i = stall_en ? rnd[0] : 1'b1;
    if (arst_n_i) begin
      case (mst)
        0: if (mem_arvalid_o) begin
          rnd = $random(seed);
          mcnt = rnd & 3;
          mst = 1;
        end
        1: if (mcnt == 0) begin
          mem_arready_i = 1'b1;
          mem_addr = mem_araddr_o;
          rnd = $random(seed);
          mcnt = rnd & 3;
          mst = 2;
        end else mcnt--;
        2: begin
          mem_arready_i = 1'b0;
          if (mcnt == 0) begin
            mem_rvalid_i = 1'b1;
            mem_rdata_i = mem_word(mem_addr);
            mst = 3;
          end else mcnt--;
        end
        default: begin
          mem_rvalid_i = 1'b0;
          mst = 0;
        end
      endcase
    end
  end

  // inputs are stable at the falling edge, so an accept here lands on the next rise
  always @(negedge clk_i) begin
    if (arst_n_i && inst_valid_o && inst_ready_i) begin
      exp_w = mem_word(model_pc);
      nxt_pc = predict_next(model_pc, exp_w, model_en, exp_t);
      check_val("inst_pc_o", inst_pc_o, model_pc);
      check_val("inst_o", {32'd0, inst_o}, {32'd0, exp_w});
      check_val("inst_pred_taken_o", {63'd0, inst_pred_taken_o}, {63'd0, exp_t});
      if (exp_t) jump_model++;
      model_pc = nxt_pc;
      acc_cnt++;
    end
  end

  initial begin
    int t;
    arst_n_i = 1'b0;
    {mem_arready_i, mem_rvalid_i, mem_rdata_i} = '0;
    {cfg_awaddr_i, cfg_awvalid_i, cfg_wdata_i, cfg_wstrb_i, cfg_wvalid_i} = '0;
    {cfg_bready_i, cfg_araddr_i, cfg_arvalid_i, cfg_rready_i} = '0;
    {redirect_valid_i, redirect_pc_i} = '0;
    inst_ready_i = 1'b1;
    {stall_en, model_en} = '0;
    model_pc = BASE;
    {errors, checks, ntests, acc_cnt, jump_model, mst, mcnt} = '0;
    prog[0] = enc_i(7'h13, 5'd0, 5'd0, 12'd0);
    prog[1] = enc_i(7'h13, 5'd5, 5'd0, 12'h10);
    prog[2] = enc_b(3'd1, 5'd5, 13'd8);
    prog[3] = enc_i(7'h13, 5'd6, 5'd5, 12'h1);
    prog[4] = enc_j(5'd1, 21'd8);
    prog[5] = enc_i(7'h13, 5'd7, 5'd0, 12'h2);
    prog[6] = enc_i(OPC_JALR, 5'd1, 5'd5, 12'h0);
    prog[7] = enc_i(OPC_JALR, 5'd0, 5'd0, 12'h124);
    prog[8] = enc_i(7'h13, 5'd8, 5'd0, 12'h3);
    prog[9] = enc_i(7'h13, 5'd9, 5'd9, 12'h1);
    prog[10] = enc_b(3'd0, 5'd0, 13'h1ffc);
    prog[11] = enc_i(7'h13, 5'd10, 5'd0, 12'h4);
    repeat (5) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    cfg_write(CFG_BOOT_LO, BASE[31:0]);
    cfg_write(CFG_BOOT_HI, BASE[63:32]);
    start_run(1'b0);
    wait_accepts(8);
    stop_run();
    report("boot_sequential");

    cfg_write(CFG_JUMP_CNT, '0);
    jump_model = 0;
    start_run(1'b1);
    wait_accepts(14);
    stop_run();
    report("prediction_enabled");

    cfg_read(CFG_JUMP_CNT, rd_val);
    check_val("jump_cnt", {32'd0, rd_val}, 64'(jump_model));
    cfg_write(CFG_JUMP_CNT, '1);
    jump_model = 0;
    cfg_read(CFG_JUMP_CNT, rd_val);
    check_val("jump_cnt", {32'd0, rd_val}, 64'd0);
    report("jump_counter");

    start_run(1'b0);
    wait_accepts(14);
    stop_run();
    report("prediction_disabled");

    start_run(1'b1);
    wait_accepts(3);
    t = 0;
    while (!mem_arvalid_o) next_cycle(t, 50, "read to redirect");
    redirect_valid_i = 1'b1;
    redirect_pc_i = RDR_PC;
    model_pc = RDR_PC;
    @(posedge clk_i);
    #1;
    redirect_valid_i = 1'b0;
    wait_accepts(6);
    stop_run();
    report("redirect");

    stall_en = 1'b1;
    start_run(1'b1);
    wait_accepts(14);
    stall_en = 1'b0;
    stop_run();
    report("back_pressure");

    $display("tests %0d, checks %0d, errors %0d", ntests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* ifu_assert.sv */
module ifu_assert (
  input logic                     clk_i,
  input logic                     arst_n_i,
  input logic [ifu_pkg::XLEN-1:0] mem_araddr_o,
  input logic                     mem_arvalid_o,
  input logic                     mem_arready_i,
  input logic                     mem_rvalid_i,
  input logic                     mem_rready_o,
  input logic                     inst_valid_o,
  input logic                     inst_ready_i,
  input logic [ifu_pkg::ILEN-1:0] inst_o,
  input logic [ifu_pkg::XLEN-1:0] inst_pc_o,
  input logic                     inst_pred_taken_o
);

  logic rd_out_q;

  // one read in flight between the AR and R handshakes
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_out_q <= 1'b0;
    end else if (mem_arvalid_o && mem_arready_i) begin
      rd_out_q <= 1'b1;
    end else if (mem_rvalid_i && mem_rready_o) begin
      rd_out_q <= 1'b0;
    end
  end

  a_araddr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_arvalid_o && !mem_arready_i |=> mem_arvalid_o && $stable(mem_araddr_o))
    else $error("araddr or arvalid changed before the AR handshake");

  a_out_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    inst_valid_o && !inst_ready_i |=> inst_valid_o && $stable(inst_o)
      && $stable(inst_pc_o) && $stable(inst_pred_taken_o))
    else $error("instruction output changed under back-pressure");

  a_rready_outstanding: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_rready_o |-> rd_out_q)
    else $error("rready high with no read outstanding");

endmodule

bind ifu_top ifu_assert u_assert (.*);

/* ifu_top.sv */
module ifu_top (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // instruction memory read channel
  output logic [ifu_pkg::XLEN-1:0]     mem_araddr_o,
  output logic                         mem_arvalid_o,
  input  logic                         mem_arready_i,
  input  logic [ifu_pkg::ILEN-1:0]     mem_rdata_i,
  input  logic                         mem_rvalid_i,
  output logic                         mem_rready_o,
  // configuration slave
  input  logic [ifu_pkg::CFG_AW-1:0]   cfg_awaddr_i,
  input  logic                         cfg_awvalid_i,
  output logic                         cfg_awready_o,
  input  logic [ifu_pkg::CFG_DW-1:0]   cfg_wdata_i,
  input  logic [ifu_pkg::CFG_DW/8-1:0] cfg_wstrb_i,
  input  logic                         cfg_wvalid_i,
  output logic                         cfg_wready_o,
  output logic [1:0]                   cfg_bresp_o,
  output logic                         cfg_bvalid_o,
  input  logic                         cfg_bready_i,
  input  logic [ifu_pkg::CFG_AW-1:0]   cfg_araddr_i,
  input  logic                         cfg_arvalid_i,
  output logic                         cfg_arready_o,
  output logic [ifu_pkg::CFG_DW-1:0]   cfg_rdata_o,
  output logic [1:0]                   cfg_rresp_o,
  output logic                         cfg_rvalid_o,
  input  logic                         cfg_rready_i,
  // back end
  input  logic                         redirect_valid_i,
  input  logic [ifu_pkg::XLEN-1:0]     redirect_pc_i,
  output logic                         inst_valid_o,
  input  logic                         inst_ready_i,
  output logic [ifu_pkg::ILEN-1:0]     inst_o,
  output logic [ifu_pkg::XLEN-1:0]     inst_pc_o,
  output logic                         inst_pred_taken_o
);
  import ifu_pkg::*;

  logic            run;
  logic            bpu_en;
  logic [XLEN-1:0] boot_pc;
  logic            fetch_req;
  logic [XLEN-1:0] fetch_pc;
  logic            fetch_kill;
  logic            fetch_done;
  logic [ILEN-1:0] fetch_inst;
  logic            pred_taken;
  logic            jump_taken;
  logic [XLEN-1:0] bpu_op1;
  logic [XLEN-1:0] bpu_op2;
  logic            bpu_valid;

  // bus ports share their names with the top level
  ifu_cfg_regs u_cfg_regs (
    .*,
    .jump_taken_i (jump_taken),
    .run_o        (run),
    .bpu_en_o     (bpu_en),
    .boot_pc_o    (boot_pc)
  );

  ifu_pc_gen u_pc_gen (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .run_i            (run),
    .bpu_en_i         (bpu_en),
    .boot_pc_i        (boot_pc),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .fetch_done_i     (fetch_done),
    .bpu_pc_op1_i     (bpu_op1),
    .bpu_pc_op2_i     (bpu_op2),
    .bpu_pc_valid_i   (bpu_valid),
    .fetch_req_o      (fetch_req),
    .fetch_pc_o       (fetch_pc),
    .fetch_kill_o     (fetch_kill),
    .pred_taken_o     (pred_taken),
    .jump_taken_o     (jump_taken)
  );

  ifu_fetch_axi u_fetch_axi (
    .*,
    .fetch_req_i  (fetch_req),
    .fetch_pc_i   (fetch_pc),
    .fetch_kill_i (fetch_kill),
    .pred_taken_i (pred_taken),
    .fetch_inst_o (fetch_inst),
    .fetch_done_o (fetch_done)
  );

  // the pc register holds the fetched word's address until fetch_done
  bpu_top u_bpu (
    .inst_data_i    (fetch_inst),
    .pc_if_i        (fetch_pc),
    .bpu_pc_op1_o   (bpu_op1),
    .bpu_pc_op2_o   (bpu_op2),
    .bpu_pc_valid_o (bpu_valid)
  );

endmodule

/* ifu_cfg_regs.sv */
module ifu_cfg_regs (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic [ifu_pkg::CFG_AW-1:0]   cfg_awaddr_i,
  input  logic                         cfg_awvalid_i,
  output logic                         cfg_awready_o,
  input  logic [ifu_pkg::CFG_DW-1:0]   cfg_wdata_i,
  input  logic [ifu_pkg::CFG_DW/8-1:0] cfg_wstrb_i,
  input  logic                         cfg_wvalid_i,
  output logic                         cfg_wready_o,
  output logic [1:0]                   cfg_bresp_o,
  output logic                         cfg_bvalid_o,
  input  logic                         cfg_bready_i,
  input  logic [ifu_pkg::CFG_AW-1:0]   cfg_araddr_i,
  input  logic                         cfg_arvalid_i,
  output logic                         cfg_arready_o,
  output logic [ifu_pkg::CFG_DW-1:0]   cfg_rdata_o,
  output logic [1:0]                   cfg_rresp_o,
  output logic                         cfg_rvalid_o,
  input  logic                         cfg_rready_i,
  input  logic                         jump_taken_i,
  output logic                         run_o,
  output logic                         bpu_en_o,
  output logic [ifu_pkg::XLEN-1:0]     boot_pc_o
);
  import ifu_pkg::*;

  logic                aw_hold_q;
  logic                w_hold_q;
  logic                bvalid_q;
  logic                rvalid_q;
  logic [CFG_AW-1:0]   awaddr_q;
  logic [CFG_DW-1:0]   wdata_q;
  logic [CFG_DW/8-1:0] wstrb_q;
  logic [CFG_DW-1:0]   rdata_q;
  logic                aw_hs;
  logic                w_hs;
  logic                do_write;
  logic [CFG_AW-1:0]   waddr;
  logic [CFG_DW-1:0]   wdata;
  logic [CFG_DW/8-1:0] wstrb;
  logic                run_q;
  logic                bpu_en_q;
  logic [XLEN-1:0]     boot_pc_q;
  logic [CFG_DW-1:0]   jump_cnt_q;
  logic [CFG_DW-1:0]   ctrl_word;
  logic [CFG_DW-1:0]   rd_word;
  logic [CFG_DW-1:0]   wr_ctrl;
  logic [CFG_DW-1:0]   wr_lo;
  logic [CFG_DW-1:0]   wr_hi;

  // byte-lane merge of a write into the current value
  function automatic logic [CFG_DW-1:0] merge_strb(input logic [CFG_DW-1:0] old_v,
                                                   input logic [CFG_DW-1:0] new_v,
                                                   input logic [CFG_DW/8-1:0] strb);
    logic [CFG_DW-1:0] res;
    res = old_v;
    for (int b = 0; b < CFG_DW/8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return res;
  endfunction

  // AW and W are taken independently, the write fires once both are in
  assign aw_hs    = cfg_awvalid_i & cfg_awready_o;
  assign w_hs     = cfg_wvalid_i & cfg_wready_o;
  assign do_write = (aw_hs | aw_hold_q) & (w_hs | w_hold_q);
  assign waddr    = aw_hold_q ? awaddr_q : cfg_awaddr_i;
  assign wdata    = w_hold_q ? wdata_q : cfg_wdata_i;
  assign wstrb    = w_hold_q ? wstrb_q : cfg_wstrb_i;

  always_comb begin
    ctrl_word                  = '0;
    ctrl_word[CTRL_RUN_BIT]    = run_q;
    ctrl_word[CTRL_BPU_EN_BIT] = bpu_en_q;
  end

  assign wr_ctrl = merge_strb(ctrl_word, wdata, wstrb);
  assign wr_lo   = merge_strb(boot_pc_q[CFG_DW-1:0], wdata, wstrb);
  assign wr_hi   = merge_strb(boot_pc_q[XLEN-1:CFG_DW], wdata, wstrb);

  always_comb begin
    case (cfg_araddr_i)
      CFG_CTRL:     rd_word = ctrl_word;
      CFG_BOOT_LO:  rd_word = boot_pc_q[CFG_DW-1:0];
      CFG_BOOT_HI:  rd_word = boot_pc_q[XLEN-1:CFG_DW];
      CFG_JUMP_CNT: rd_word = jump_cnt_q;
      default:      rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aw_hold_q  <= 1'b0;
      w_hold_q   <= 1'b0;
      bvalid_q   <= 1'b0;
      rvalid_q   <= 1'b0;
      run_q      <= 1'b0;
      bpu_en_q   <= 1'b0;
      boot_pc_q  <= '0;
      jump_cnt_q <= '0;
    end else begin
      aw_hold_q <= ~do_write & (aw_hold_q | aw_hs);
      w_hold_q  <= ~do_write & (w_hold_q | w_hs);

      if (do_write) begin
        bvalid_q <= 1'b1;
      end else if (cfg_bready_i) begin
        bvalid_q <= 1'b0;
      end

      if (cfg_arvalid_i && cfg_arready_o) begin
        rvalid_q <= 1'b1;
      end else if (cfg_rready_i) begin
        rvalid_q <= 1'b0;
      end

      if (do_write) begin
        case (waddr)
          CFG_CTRL: begin
            run_q    <= wr_ctrl[CTRL_RUN_BIT];
            bpu_en_q <= wr_ctrl[CTRL_BPU_EN_BIT];
          end
          CFG_BOOT_LO: boot_pc_q[CFG_DW-1:0]    <= wr_lo;
          CFG_BOOT_HI: boot_pc_q[XLEN-1:CFG_DW] <= wr_hi;
          default: ;
        endcase
      end

      // any write to the counter clears it, otherwise count up and stick at max
      if (do_write && (waddr == CFG_JUMP_CNT)) begin
        jump_cnt_q <= '0;
      end else if (jump_taken_i && (jump_cnt_q != '1)) begin
        jump_cnt_q <= jump_cnt_q + CFG_DW'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      awaddr_q <= cfg_awaddr_i;
    end
    if (w_hs) begin
      wdata_q <= cfg_wdata_i;
      wstrb_q <= cfg_wstrb_i;
    end
    if (cfg_arvalid_i && cfg_arready_o) begin
      rdata_q <= rd_word;
    end
  end

  assign cfg_awready_o = ~aw_hold_q & ~bvalid_q;
  assign cfg_wready_o  = ~w_hold_q & ~bvalid_q;
  assign cfg_bresp_o   = AXI_RESP_OKAY;
  assign cfg_bvalid_o  = bvalid_q;
  assign cfg_arready_o = ~rvalid_q;
  assign cfg_rdata_o   = rdata_q;
  assign cfg_rresp_o   = AXI_RESP_OKAY;
  assign cfg_rvalid_o  = rvalid_q;

  assign run_o     = run_q;
  assign bpu_en_o  = bpu_en_q;
  assign boot_pc_o = boot_pc_q;

endmodule

/* ifu_fetch_axi.sv */
module ifu_fetch_axi (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     fetch_req_i,
  input  logic [ifu_pkg::XLEN-1:0] fetch_pc_i,
  input  logic                     fetch_kill_i,
  input  logic                     pred_taken_i,
  output logic [ifu_pkg::XLEN-1:0] mem_araddr_o,
  output logic                     mem_arvalid_o,
  input  logic                     mem_arready_i,
  input  logic [ifu_pkg::ILEN-1:0] mem_rdata_i,
  input  logic                     mem_rvalid_i,
  output logic                     mem_rready_o,
  output logic [ifu_pkg::ILEN-1:0] fetch_inst_o,
  output logic                     fetch_done_o,
  output logic                     inst_valid_o,
  input  logic                     inst_ready_i,
  output logic [ifu_pkg::ILEN-1:0] inst_o,
  output logic [ifu_pkg::XLEN-1:0] inst_pc_o,
  output logic                     inst_pred_taken_o
);
  import ifu_pkg::*;

  logic [1:0]      state_q;
  logic            arvalid_q;
  logic [XLEN-1:0] araddr_q;
  logic [ILEN-1:0] inst_q;
  logic            issue;
  logic            drop;
  logic            accept;

  assign issue  = (state_q == FS_ADDR) & ~arvalid_q & fetch_req_i;
  // killed response is taken off R here and never reaches the output
  assign drop   = (state_q == FS_DATA) & mem_rvalid_i & fetch_kill_i;
  assign accept = (state_q == FS_PRES) & inst_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= FS_ADDR;
      arvalid_q <= 1'b0;
    end else begin
      case (state_q)
        FS_ADDR: begin
          if (arvalid_q && mem_arready_i) begin
            arvalid_q <= 1'b0;
            state_q   <= FS_DATA;
          end else if (issue) begin
            arvalid_q <= 1'b1;
          end
        end
        FS_DATA: begin
          if (mem_rvalid_i) begin
            state_q <= fetch_kill_i ? FS_ADDR : FS_PRES;
          end
        end
        FS_PRES: begin
          if (inst_ready_i) begin
            state_q <= FS_ADDR;
          end
        end
        default: state_q <= FS_ADDR;
      endcase
    end
  end

  // address and word are held until the instruction is accepted
  always_ff @(posedge clk_i) begin
    if (issue) begin
      araddr_q <= fetch_pc_i;
    end
    if ((state_q == FS_DATA) && mem_rvalid_i) begin
      inst_q <= mem_rdata_i;
    end
  end

  assign mem_araddr_o  = araddr_q;
  assign mem_arvalid_o = arvalid_q;
  assign mem_rready_o  = (state_q == FS_DATA);

  assign fetch_inst_o = inst_q;
  assign fetch_done_o = drop | accept;

  assign inst_valid_o      = (state_q == FS_PRES);
  assign inst_o            = inst_q;
  assign inst_pc_o         = araddr_q;
  assign inst_pred_taken_o = pred_taken_i & inst_valid_o;

endmodule

/* ifu_pc_gen.sv */
module ifu_pc_gen (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     run_i,
  input  logic                     bpu_en_i,
  input  logic [ifu_pkg::XLEN-1:0] boot_pc_i,
  input  logic                     redirect_valid_i,
  input  logic [ifu_pkg::XLEN-1:0] redirect_pc_i,
  input  logic                     fetch_done_i,
  input  logic [ifu_pkg::XLEN-1:0] bpu_pc_op1_i,
  input  logic [ifu_pkg::XLEN-1:0] bpu_pc_op2_i,
  input  logic                     bpu_pc_valid_i,
  output logic                     fetch_req_o,
  output logic [ifu_pkg::XLEN-1:0] fetch_pc_o,
  output logic                     fetch_kill_o,
  output logic                     pred_taken_o,
  output logic                     jump_taken_o
);
  import ifu_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_seq;
  logic [XLEN-1:0] pc_pred;
  logic            fetching_q;
  logic            kill_q;
  logic            run_q;
  logic            boot_load;
  logic            taken;

  assign boot_load = run_i & ~run_q;
  assign taken     = bpu_en_i & bpu_pc_valid_i;
  assign pc_seq    = pc_q + XLEN'(4);
  assign pc_pred   = bpu_pc_op1_i + bpu_pc_op2_i;

  // any pc overwrite during a fetch kills the read in flight
  assign fetch_kill_o = kill_q | (fetching_q & (redirect_valid_i | boot_load));

  // hold off in the boot and redirect cycles so the request sees the new pc
  assign fetch_req_o  = run_i & run_q & ~fetching_q & ~redirect_valid_i;
  assign fetch_pc_o   = pc_q;
  assign pred_taken_o = taken;
  assign jump_taken_o = fetch_done_i & taken & ~fetch_kill_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q       <= '0;
      fetching_q <= 1'b0;
      kill_q     <= 1'b0;
      run_q      <= 1'b0;
    end else begin
      run_q <= run_i;

      // redirect beats boot, boot beats the prediction
      if (redirect_valid_i) begin
        pc_q <= redirect_pc_i;
      end else if (boot_load) begin
        pc_q <= boot_pc_i;
      end else if (fetch_done_i && !kill_q) begin
        pc_q <= taken ? pc_pred : pc_seq;
      end

      if (fetch_done_i) begin
        fetching_q <= 1'b0;
      end else if (fetch_req_o) begin
        fetching_q <= 1'b1;
      end

      if (fetch_done_i) begin
        kill_q <= 1'b0;
      end else if (fetching_q && (redirect_valid_i || boot_load)) begin
        kill_q <= 1'b1;
      end
    end
  end

endmodule

/* bpu_top.sv */
module bpu_top (
  input  logic [ifu_pkg::ILEN-1:0] inst_data_i,
  input  logic [ifu_pkg::XLEN-1:0] pc_if_i,
  output logic [ifu_pkg::XLEN-1:0] bpu_pc_op1_o,
  output logic [ifu_pkg::XLEN-1:0] bpu_pc_op2_o,
  output logic                     bpu_pc_valid_o
);
  import ifu_pkg::*;

  rv_inst_u        inst;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic            is_branch;
  logic            is_jalr;
  logic            is_jal;
  logic            rs1_zero;

  assign inst = inst_data_i;

  // sign-extended immediates, B and J carry an implicit zero lsb
  assign imm_i = {{(XLEN-12){inst.i.imm[11]}}, inst.i.imm};
  assign imm_b = {{(XLEN-13){inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                  inst.b.imm10_5, inst.b.imm4_1, 1'b0};
  assign imm_j = {{(XLEN-21){inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                  inst.j.imm11, inst.j.imm10_1, 1'b0};

  assign is_branch = (inst.i.opcode == OPC_BRANCH);
  assign is_jalr   = (inst.i.opcode == OPC_JALR);
  assign is_jal    = (inst.i.opcode == OPC_JAL);
  assign rs1_zero  = (inst.i.rs1 == 5'd0);

  // target operands, summed by the pc generator
  always_comb begin
    bpu_pc_op1_o = '0;
    bpu_pc_op2_o = '0;
    if (is_branch) begin
      bpu_pc_op1_o = pc_if_i;
      bpu_pc_op2_o = imm_b;
    end else if (is_jal) begin
      bpu_pc_op1_o = pc_if_i;
      bpu_pc_op2_o = imm_j;
    end else if (is_jalr) begin
      // only x0 as base is known here, so the target is the immediate alone
      bpu_pc_op2_o = imm_i;
    end
  end

  // backward taken, forward not taken; jal always; jalr only off x0
  assign bpu_pc_valid_o = (is_branch & imm_b[XLEN-1])
                        | is_jal
                        | (is_jalr & rs1_zero);

endmodule

/* ifu_pkg.sv */
package ifu_pkg;

  // datapath widths
  localparam int XLEN = 64;
  localparam int ILEN = 32;

  // configuration bus geometry
  localparam int CFG_AW = 4;
  localparam int CFG_DW = 32;
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // major opcodes of the control-transfer instructions
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // configuration register byte offsets
  localparam logic [CFG_AW-1:0] CFG_CTRL     = 4'h0;
  localparam logic [CFG_AW-1:0] CFG_BOOT_LO  = 4'h4;
  localparam logic [CFG_AW-1:0] CFG_BOOT_HI  = 4'h8;
  localparam logic [CFG_AW-1:0] CFG_JUMP_CNT = 4'hc;

  // control register fields
  localparam int CTRL_RUN_BIT    = 0;
  localparam int CTRL_BPU_EN_BIT = 1;

  // fetch master states, idle is FS_ADDR with arvalid low
  localparam logic [1:0] FS_ADDR = 2'd0;
  localparam logic [1:0] FS_DATA = 2'd1;
  localparam logic [1:0] FS_PRES = 2'd2;

  // one instruction word seen through the immediate formats
  typedef union packed {
    logic [ILEN-1:0] word;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic        imm12;
      logic [5:0]  imm10_5;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [3:0]  imm4_1;
      logic        imm11;
      logic [6:0]  opcode;
    } b;
    struct packed {
      logic        imm20;
      logic [9:0]  imm10_1;
      logic        imm11;
      logic [7:0]  imm19_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } j;
  } rv_inst_u;

endpackage
